/* Bender.yml */
package:
  name: ldpc_alu

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/alu_pkg.sv
      - verilog/alu_operands_if.sv
      - verilog/alu_arith.sv
      - verilog/alu_shifter.sv
      - verilog/ldpc_simd_unit.sv
      - verilog/alu_result_stage.sv
      - verilog/ldpc_alu_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/ldpc_alu_tb.sv

/* all.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_operands_if.sv
verilog/alu_arith.sv
verilog/alu_shifter.sv
verilog/ldpc_simd_unit.sv
verilog/alu_result_stage.sv
verilog/ldpc_alu_top.sv
dv/tb_clock_gen.sv
dv/ldpc_alu_tb.sv

/* dv/ldpc_alu_tb.sv */
// ---------------------------------------------------------------------------
// LDPC execute unit testbench with stimulus, reference model,
// checking assertions, watchdog and reporting
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module ldpc_alu_tb;

    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_OPS    = 60 + 200 + 144 + 320 + 320;
    // Twice the run length in 4 ns cycles plus margin
    localparam int WATCHDOG_NS  = (TOTAL_OPS + RESET_CYCLES + 5 * 3) * 4 * 2 + 100;

    logic             clk_i;
    logic             reset_i;
    logic             issue_valid_i;
    alu_pkg::alu_op_e op_i;
    alu_pkg::xlen_t   operand_a_i;
    alu_pkg::xlen_t   operand_b_i;
    alu_pkg::xlen_t   imm_i;
    alu_pkg::xlen_t   result_o;
    logic             branch_res_o;
    logic             result_valid_o;

    // Expected values of the last issue, and what the outputs show this cycle
    alu_pkg::xlen_t   exp_result;
    logic             exp_branch;
    alu_pkg::xlen_t   chk_result;
    logic             chk_branch;
    logic             chk_valid;

    // Operand staging for the shift and compare tests
    alu_pkg::xlen_t   cmp_a;
    logic [5:0]       shamt;

    string            test_name;
    int               error_count;
    int               errors_at_start;
    int               tests_run;
    int               tests_failed;
    int               issued;

    tb_clock_gen clock_gen_i (
        .clk_o (clk_i)
    );

    ldpc_alu_top dut_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .issue_valid_i  (issue_valid_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .imm_i          (imm_i),
        .result_o       (result_o),
        .branch_res_o   (branch_res_o),
        .result_valid_o (result_valid_o)
    );

    // -----------------------------------------------------------------------
    // Checks one cycle after each issue and while holding
    // -----------------------------------------------------------------------
    result_ok: assert property (@(posedge clk_i) disable iff (reset_i)
                                result_o == chk_result)
        else begin
            error_count++;
            $display("MISMATCH %s result expected %h actual %h",
                     test_name, chk_result, $sampled(result_o));
        end

    branch_ok: assert property (@(posedge clk_i) disable iff (reset_i)
                                branch_res_o == chk_branch)
        else begin
            error_count++;
            $display("MISMATCH %s branch expected %b actual %b",
                     test_name, chk_branch, $sampled(branch_res_o));
        end

    valid_ok: assert property (@(posedge clk_i) disable iff (reset_i)
                               result_valid_o == chk_valid)
        else begin
            error_count++;
            $display("MISMATCH %s valid expected %b actual %b",
                     test_name, chk_valid, $sampled(result_valid_o));
        end

    // -----------------------------------------------------------------------
    // Reference model
    // -----------------------------------------------------------------------
    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic int sat(input int v);
        if (v > `ALU_SAT_MAX) return `ALU_SAT_MAX;
        if (v < -`ALU_SAT_MAX) return -`ALU_SAT_MAX;
        return v;
    endfunction

    function automatic logic [7:0] lane_ref(input alu_pkg::alu_op_e op, input int a, b, c);
        int r;
        int t;
        case (op)
            alu_pkg::LDPC_SIGN:        r = (a < 0) ? 1 : 0;
            alu_pkg::LDPC_MIN:         r = (a >= b) ? b : a;
            alu_pkg::LDPC_ABS:         r = (a >= 0) ? a : -a;
            alu_pkg::LDPC_ADD_SAT:     r = sat(a + b);
            alu_pkg::LDPC_SUB_SAT:     r = sat(a - b);
            alu_pkg::LDPC_MINMAX:      r = (c < ((a > b) ? a : b)) ? c : ((a > b) ? a : b);
            alu_pkg::LDPC_MIN_SORTING: r = (a == b) ? c : a;
            alu_pkg::LDPC_RSIGN_NMESS: begin
                t = (b >= 0) ? (a ^ 1) : a;
                r = (t >= 1) ? c : -c;
            end
            default:                   r = 0;
        endcase
        return r[7:0];
    endfunction

    task automatic ref_model(input alu_pkg::alu_op_e op, input logic [63:0] a, b, c,
                             output logic [63:0] res, output logic br);
        logic [5:0] sh;
        logic [4:0] shw;
        sh  = b[5:0];
        shw = b[4:0];
        res = '0;
        br  = 1'b1;
        case (op)
            alu_pkg::ADD:  res = a + b;
            alu_pkg::SUB:  res = a - b;
            alu_pkg::ADDW: res = sext32(a[31:0] + b[31:0]);
            alu_pkg::SUBW: res = sext32(a[31:0] - b[31:0]);
            alu_pkg::ANDL: res = a & b;
            alu_pkg::ORL:  res = a | b;
            alu_pkg::XORL: res = a ^ b;
            alu_pkg::ANDN: res = a & ~b;
            alu_pkg::ORN:  res = a | ~b;
            alu_pkg::XNOR: res = ~(a ^ b);
            alu_pkg::SLL:  res = a << sh;
            alu_pkg::SRL:  res = a >> sh;
            alu_pkg::SRA:  res = $signed(a) >>> sh;
            alu_pkg::SLLW: res = sext32(a[31:0] << shw);
            alu_pkg::SRLW: res = sext32(a[31:0] >> shw);
            alu_pkg::SRAW: res = sext32($signed(a[31:0]) >>> shw);
            alu_pkg::SLTS: res = {63'b0, $signed(a) < $signed(b)};
            alu_pkg::SLTU: res = {63'b0, a < b};
            alu_pkg::EQ:   br = (a == b);
            alu_pkg::NE:   br = (a != b);
            alu_pkg::LTS:  br = ($signed(a) < $signed(b));
            alu_pkg::LTU:  br = (a < b);
            alu_pkg::GES:  br = ($signed(a) >= $signed(b));
            alu_pkg::GEU:  br = (a >= b);
            default: begin
                for (int i = 0; i < `ALU_LANES; i++) begin
                    res[8*i +: 8] = lane_ref(op, int'($signed(a[8*i +: 8])),
                                             int'($signed(b[8*i +: 8])),
                                             int'($signed(c[8*i +: 8])));
                end
            end
        endcase
    endtask

    // -----------------------------------------------------------------------
    // Stimulus helpers
    // -----------------------------------------------------------------------
    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // Lanes mixing random bytes with -128, -127, 0 and 127
    function automatic logic [63:0] rand_lanes();
        logic [63:0] w;
        for (int i = 0; i < `ALU_LANES; i++) begin
            case ($urandom_range(5))
                0:       w[8*i +: 8] = 8'h80;
                1:       w[8*i +: 8] = 8'h81;
                2:       w[8*i +: 8] = 8'h00;
                3:       w[8*i +: 8] = 8'h7f;
                default: w[8*i +: 8] = 8'($urandom);
            endcase
        end
        return w;
    endfunction

    // Each falling edge moves the last expectation into the checker and drives new inputs
    task automatic drive(input logic valid, input alu_pkg::alu_op_e op,
                         input logic [63:0] a, b, c);
        @(negedge clk_i);
        chk_valid     = issue_valid_i;
        chk_result    = exp_result;
        chk_branch    = exp_branch;
        issue_valid_i = valid;
        op_i          = op;
        operand_a_i   = a;
        operand_b_i   = b;
        imm_i         = c;
        if (valid) begin
            ref_model(op, a, b, c, exp_result, exp_branch);
            issued++;
        end
    endtask

    task automatic idle_cycle();
        drive(1'b0, alu_pkg::alu_op_e'($urandom_range(31)), rand_word(), rand_word(),
              rand_word());
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        int errs;
        repeat (3) idle_cycle();
        errs = error_count - errors_at_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("%-14s %s (%0d errors)", test_name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // -----------------------------------------------------------------------
    // Test sequence
    // -----------------------------------------------------------------------
    initial begin
        void'($urandom(43));
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        op_i          = alu_pkg::ADD;
        operand_a_i   = '0;
        operand_b_i   = '0;
        imm_i         = '0;
        exp_result    = '0;
        exp_branch    = 1'b0;
        chk_result    = '0;
        chk_branch    = 1'b0;
        chk_valid     = 1'b0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        issued        = 0;
        start_test("reset");
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;

        start_test("reset_valid");
        reset_clear: assert (result_valid_o == 1'b0 && result_o == '0 && branch_res_o == 1'b0)
            else begin
                error_count++;
                $display("Outputs were not cleared by reset");
            end
        for (int k = 0; k < 60; k++) begin
            drive(1'($urandom), alu_pkg::alu_op_e'($urandom_range(31)), rand_word(),
                  rand_word(), rand_lanes());
        end
        end_test();

        start_test("arith_logic");
        for (int k = 0; k < 200; k++) begin
            drive(1'b1, alu_pkg::alu_op_e'($urandom_range(9)), rand_word(), rand_word(), '0);
        end
        end_test();

        start_test("shifts");
        for (int op = alu_pkg::SLL; op <= alu_pkg::SRAW; op++) begin
            for (int k = 0; k < 24; k++) begin
                shamt = (k == 0) ? 6'd0 : (k == 1) ? 6'd31 :
                        (k == 2) ? 6'd32 : (k == 3) ? 6'd63 : 6'($urandom);
                drive(1'b1, alu_pkg::alu_op_e'(op), rand_word(),
                      (rand_word() & ~64'h3f) | {58'b0, shamt}, '0);
            end
        end
        end_test();

        // Equal operands, sign-bit-only differences and random pairs
        start_test("compare_branch");
        for (int op = alu_pkg::SLTS; op <= alu_pkg::GEU; op++) begin
            for (int k = 0; k < 40; k++) begin
                cmp_a = rand_word();
                drive(1'b1, alu_pkg::alu_op_e'(op), cmp_a,
                      (k % 3 == 0) ? cmp_a :
                      (k % 3 == 1) ? cmp_a ^ 64'h8000_0000_0000_0000 : rand_word(),
                      '0);
            end
        end
        end_test();

        start_test("ldpc_lanes");
        for (int op = alu_pkg::LDPC_SIGN; op <= alu_pkg::LDPC_RSIGN_NMESS; op++) begin
            for (int k = 0; k < 40; k++) begin
                drive(1'b1, alu_pkg::alu_op_e'(op), rand_lanes(), rand_lanes(), rand_lanes());
            end
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d operations issued, %0d errors",
                 tests_run, tests_failed, issued, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out in test %s", test_name);
        $display("Test failed");
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
// ---------------------------------------------------------------------------
// Free-running testbench clock, 4 ns period
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o
);

    localparam real HALF_PERIOD_NS = 2.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

/* verilog/alu_arith.sv */
// ---------------------------------------------------------------------------
// Adder, logic operations, less-than compare and branch resolution
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module alu_arith (
    alu_operands_if.sink   ops_i,
    output alu_pkg::xlen_t adder_result_o,
    output alu_pkg::xlen_t logic_result_o,
    output logic           less_o,
    output logic           branch_res_o
);

    logic               b_negate;
    logic               cmp_signed;
    logic               zero_flag;
    logic [`ALU_XLEN:0] adder_in_a;
    logic [`ALU_XLEN:0] operand_b_neg;
    logic [`ALU_XLEN:0] adder_sum;

    // -----------------------------------------------------------------------
    // Adder
    // -----------------------------------------------------------------------
    always_comb begin
        case (ops_i.op)
            alu_pkg::SUB, alu_pkg::SUBW,
            alu_pkg::EQ, alu_pkg::NE,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: b_negate = 1'b1;
            default:                                    b_negate = 1'b0;
        endcase
    end

    // Extra LSB carries the one that turns ~B into -B
    assign adder_in_a     = {ops_i.operand_a.word, 1'b1};
    assign operand_b_neg  = {ops_i.operand_b.word, 1'b0} ^ {(`ALU_XLEN+1){b_negate}};
    assign adder_sum      = adder_in_a + operand_b_neg;
    assign adder_result_o = adder_sum[`ALU_XLEN:1];
    assign zero_flag      = ~|adder_result_o;

    // Logic on the possibly inverted B
    always_comb begin
        case (ops_i.op)
            alu_pkg::ANDL, alu_pkg::ANDN:
                logic_result_o = ops_i.operand_a.word & operand_b_neg[`ALU_XLEN:1];
            alu_pkg::ORL, alu_pkg::ORN:
                logic_result_o = ops_i.operand_a.word | operand_b_neg[`ALU_XLEN:1];
            alu_pkg::XORL, alu_pkg::XNOR:
                logic_result_o = ops_i.operand_a.word ^ operand_b_neg[`ALU_XLEN:1];
            default:
                logic_result_o = '0;
        endcase
    end

    // -----------------------------------------------------------------------
    // Compare and branch
    // -----------------------------------------------------------------------
    assign cmp_signed = (ops_i.op == alu_pkg::SLTS) || (ops_i.op == alu_pkg::LTS) ||
                        (ops_i.op == alu_pkg::GES);

    assign less_o = $signed({cmp_signed & ops_i.operand_a.word[`ALU_XLEN-1],
                             ops_i.operand_a.word}) <
                    $signed({cmp_signed & ops_i.operand_b.word[`ALU_XLEN-1],
                             ops_i.operand_b.word});

    always_comb begin
        case (ops_i.op)
            alu_pkg::EQ:                 branch_res_o = zero_flag;
            alu_pkg::NE:                 branch_res_o = ~zero_flag;
            alu_pkg::LTS, alu_pkg::LTU:  branch_res_o = less_o;
            alu_pkg::GES, alu_pkg::GEU:  branch_res_o = ~less_o;
            default:                     branch_res_o = 1'b1;
        endcase
    end

endmodule

/* verilog/alu_consts.svh */
// ---------------------------------------------------------------------------
// Width and bound constants of the LDPC execute unit
// ---------------------------------------------------------------------------
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Scalar datapath
`define ALU_XLEN     64
`define ALU_WORD_W   32

// SIMD lanes for the LDPC messages
`define ALU_LANES    8
`define ALU_LANE_W   8

// Shift amounts, 64-bit and word forms
`define ALU_SHAMT_W  6
`define ALU_SHAMTW_W 5

// Largest magnitude after saturating add or subtract
`define ALU_SAT_MAX  127

// Operator encoding
`define ALU_OP_W     6

`endif

/* verilog/alu_operands_if.sv */
// ---------------------------------------------------------------------------
// Decoded operation and operands shared by all datapath units
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

interface alu_operands_if;

    alu_pkg::alu_op_e   op;
    alu_pkg::alu_word_u operand_a;
    alu_pkg::alu_word_u operand_b;
    // Third operand, only read by the LDPC operations
    alu_pkg::alu_word_u imm;

    modport source (
        output op, operand_a, operand_b, imm
    );

    modport sink (
        input op, operand_a, operand_b, imm
    );

endinterface

/* verilog/alu_pkg.sv */
// ---------------------------------------------------------------------------
// Operator encoding and data types of the LDPC execute unit
// ---------------------------------------------------------------------------
package alu_pkg;

`include "alu_consts.svh"

    typedef enum logic [`ALU_OP_W-1:0] {
        // Adder
        ADD, SUB, ADDW, SUBW,
        // Logic, with B-inverted forms
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        // Shifts
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // Set less than
        SLTS, SLTU,
        // Branch compares
        EQ, NE, LTS, LTU, GES, GEU,
        // LDPC lane operations
        LDPC_SIGN, LDPC_MIN, LDPC_ABS, LDPC_ADD_SAT, LDPC_SUB_SAT,
        LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS
    } alu_op_e;

    typedef logic [`ALU_XLEN-1:0] xlen_t;

    // One signed LDPC message
    typedef logic signed [`ALU_LANE_W-1:0] lane_t;

    // Scalar units see a word, the LDPC unit sees lanes (lane 0 low)
    typedef union packed {
        xlen_t                     word;
        lane_t [`ALU_LANES-1:0]    lanes;
    } alu_word_u;

endpackage

/* verilog/alu_result_stage.sv */
// ---------------------------------------------------------------------------
// Result select, word sign extension and the registered output stage
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module alu_result_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   issue_valid_i,
    alu_operands_if.sink           ops_i,
    input  alu_pkg::xlen_t         adder_result_i,
    input  alu_pkg::xlen_t         logic_result_i,
    input  alu_pkg::xlen_t         shift_result_i,
    input  logic [`ALU_WORD_W-1:0] shift_word_result_i,
    input  logic                   less_i,
    input  logic                   branch_res_i,
    input  alu_pkg::alu_word_u     ldpc_result_i,
    output alu_pkg::xlen_t         result_o,
    output logic                   branch_res_o,
    output logic                   result_valid_o
);

    alu_pkg::xlen_t result_d;

    // -----------------------------------------------------------------------
    // Result select
    // -----------------------------------------------------------------------
    always_comb begin
        case (ops_i.op)
            alu_pkg::ADD, alu_pkg::SUB:
                result_d = adder_result_i;
            // Word adds keep the low half, sign-extended
            alu_pkg::ADDW, alu_pkg::SUBW:
                result_d = {{(`ALU_XLEN-`ALU_WORD_W){adder_result_i[`ALU_WORD_W-1]}},
                            adder_result_i[`ALU_WORD_W-1:0]};
            alu_pkg::ANDL, alu_pkg::ORL, alu_pkg::XORL,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR:
                result_d = logic_result_i;
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA:
                result_d = shift_result_i;
            alu_pkg::SLLW, alu_pkg::SRLW, alu_pkg::SRAW:
                result_d = {{(`ALU_XLEN-`ALU_WORD_W){shift_word_result_i[`ALU_WORD_W-1]}},
                            shift_word_result_i};
            alu_pkg::SLTS, alu_pkg::SLTU:
                result_d = {{(`ALU_XLEN-1){1'b0}}, less_i};
            alu_pkg::LDPC_SIGN, alu_pkg::LDPC_MIN, alu_pkg::LDPC_ABS,
            alu_pkg::LDPC_ADD_SAT, alu_pkg::LDPC_SUB_SAT, alu_pkg::LDPC_MINMAX,
            alu_pkg::LDPC_MIN_SORTING, alu_pkg::LDPC_RSIGN_NMESS:
                result_d = ldpc_result_i.word;
            // Branches only produce a decision
            default:
                result_d = '0;
        endcase
    end

    // -----------------------------------------------------------------------
    // Output registers
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
            branch_res_o   <= 1'b0;
        end else begin
            result_valid_o <= issue_valid_i;
            // Hold the last result while idle
            if (issue_valid_i) begin
                result_o     <= result_d;
                branch_res_o <= branch_res_i;
            end
        end
    end

endmodule

/* verilog/alu_shifter.sv */
// ---------------------------------------------------------------------------
// 64-bit and word shifter, left shifts done by bit reversal
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module alu_shifter (
    alu_operands_if.sink           ops_i,
    output alu_pkg::xlen_t         shift_result_o,
    output logic [`ALU_WORD_W-1:0] shift_word_result_o
);

    logic                   shift_left;
    logic                   shift_arith;
    alu_pkg::xlen_t         shift_in;
    alu_pkg::xlen_t         left_result;
    logic [`ALU_WORD_W-1:0] shift_in32;
    logic [`ALU_WORD_W-1:0] left_result32;
    logic [`ALU_XLEN:0]     right_result;
    logic [`ALU_WORD_W:0]   right_result32;

    assign shift_left  = (ops_i.op == alu_pkg::SLL) || (ops_i.op == alu_pkg::SLLW);
    assign shift_arith = (ops_i.op == alu_pkg::SRA) || (ops_i.op == alu_pkg::SRAW);

    // Reverse A for left shifts so one right shifter serves both
    always_comb begin
        for (int k = 0; k < `ALU_XLEN; k++) begin
            shift_in[k] = shift_left ? ops_i.operand_a.word[`ALU_XLEN-1-k]
                                     : ops_i.operand_a.word[k];
        end
        for (int k = 0; k < `ALU_WORD_W; k++) begin
            shift_in32[k] = shift_left ? ops_i.operand_a.word[`ALU_WORD_W-1-k]
                                       : ops_i.operand_a.word[k];
        end
    end

    // Sign fill only for the arithmetic forms
    assign right_result   = $unsigned($signed({shift_arith & shift_in[`ALU_XLEN-1], shift_in})
                            >>> ops_i.operand_b.word[`ALU_SHAMT_W-1:0]);
    assign right_result32 = $unsigned($signed({shift_arith & shift_in32[`ALU_WORD_W-1],
                                               shift_in32})
                            >>> ops_i.operand_b.word[`ALU_SHAMTW_W-1:0]);

    // Undo the reversal
    always_comb begin
        for (int k = 0; k < `ALU_XLEN; k++) begin
            left_result[k] = right_result[`ALU_XLEN-1-k];
        end
        for (int k = 0; k < `ALU_WORD_W; k++) begin
            left_result32[k] = right_result32[`ALU_WORD_W-1-k];
        end
    end

    assign shift_result_o      = shift_left ? left_result : right_result[`ALU_XLEN-1:0];
    assign shift_word_result_o = shift_left ? left_result32 : right_result32[`ALU_WORD_W-1:0];

endmodule

/* verilog/ldpc_alu_top.sv */
// ---------------------------------------------------------------------------
// Execute unit top level with the datapath units and output stage
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module ldpc_alu_top (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             issue_valid_i,
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    input  alu_pkg::xlen_t   imm_i,
    output alu_pkg::xlen_t   result_o,
    output logic             branch_res_o,
    output logic             result_valid_o
);

    alu_pkg::xlen_t         adder_result;
    alu_pkg::xlen_t         logic_result;
    alu_pkg::xlen_t         shift_result;
    logic [`ALU_WORD_W-1:0] shift_word_result;
    logic                   less;
    logic                   branch_res;
    alu_pkg::alu_word_u     ldpc_result;

    alu_operands_if ops ();

    // Ports into the shared operand bundle
    assign ops.op             = op_i;
    assign ops.operand_a.word = operand_a_i;
    assign ops.operand_b.word = operand_b_i;
    assign ops.imm.word       = imm_i;

    alu_arith arith_i (
        .ops_i          (ops.sink),
        .adder_result_o (adder_result),
        .logic_result_o (logic_result),
        .less_o         (less),
        .branch_res_o   (branch_res)
    );

    alu_shifter shifter_i (
        .ops_i               (ops.sink),
        .shift_result_o      (shift_result),
        .shift_word_result_o (shift_word_result)
    );

    ldpc_simd_unit ldpc_i (
        .ops_i         (ops.sink),
        .ldpc_result_o (ldpc_result)
    );

    alu_result_stage result_stage_i (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .issue_valid_i       (issue_valid_i),
        .ops_i               (ops.sink),
        .adder_result_i      (adder_result),
        .logic_result_i      (logic_result),
        .shift_result_i      (shift_result),
        .shift_word_result_i (shift_word_result),
        .less_i              (less),
        .branch_res_i        (branch_res),
        .ldpc_result_i       (ldpc_result),
        .result_o            (result_o),
        .branch_res_o        (branch_res_o),
        .result_valid_o      (result_valid_o)
    );

endmodule

/* verilog/ldpc_simd_unit.sv */
// ---------------------------------------------------------------------------
// Eight-lane LDPC message operations and their selection
// ---------------------------------------------------------------------------
`timescale 1ns/100ps

`include "alu_consts.svh"

module ldpc_simd_unit (
    alu_operands_if.sink       ops_i,
    output alu_pkg::alu_word_u ldpc_result_o
);

    // Clamp a 9-bit lane sum to the symmetric message range
    function automatic alu_pkg::lane_t saturate(input logic signed [`ALU_LANE_W:0] v);
        alu_pkg::lane_t s;
        if (v > `ALU_SAT_MAX) begin
            s = alu_pkg::lane_t'(`ALU_SAT_MAX);
        end else if (v < -`ALU_SAT_MAX) begin
            s = alu_pkg::lane_t'(-`ALU_SAT_MAX);
        end else begin
            s = alu_pkg::lane_t'(v);
        end
        return s;
    endfunction

    always_comb begin
        alu_pkg::lane_t               a;
        alu_pkg::lane_t               b;
        alu_pkg::lane_t               c;
        alu_pkg::lane_t               max_ab;
        alu_pkg::lane_t               t;
        alu_pkg::lane_t               res;
        logic signed [`ALU_LANE_W:0]  sum;
        logic signed [`ALU_LANE_W:0]  diff;

        ldpc_result_o = '0;
        for (int i = 0; i < `ALU_LANES; i++) begin
            a = ops_i.operand_a.lanes[i];
            b = ops_i.operand_b.lanes[i];
            c = ops_i.imm.lanes[i];

            // 9-bit results so overflow is visible
            sum    = a + b;
            diff   = a - b;
            max_ab = (a >= b) ? a : b;

            // Flip the LSB of a when b is non-negative
            t = {a[`ALU_LANE_W-1:1], a[0] ^ ~b[`ALU_LANE_W-1]};

            case (ops_i.op)
                alu_pkg::LDPC_SIGN:
                    res = (a < 0) ? alu_pkg::lane_t'(1) : '0;
                alu_pkg::LDPC_MIN:
                    res = (a >= b) ? b : a;
                alu_pkg::LDPC_ABS:
                    res = (a >= 0) ? a : -a;
                alu_pkg::LDPC_ADD_SAT:
                    res = saturate(sum);
                alu_pkg::LDPC_SUB_SAT:
                    res = saturate(diff);
                alu_pkg::LDPC_MINMAX:
                    res = (c >= max_ab) ? max_ab : c;
                alu_pkg::LDPC_MIN_SORTING:
                    res = (a == b) ? c : a;
                alu_pkg::LDPC_RSIGN_NMESS:
                    res = (t >= 1) ? c : -c;
                default:
                    res = '0;
            endcase

            ldpc_result_o.lanes[i] = res;
        end
    end

endmodule
